// File: files.f
src/input_pipe_pkg.sv
src/im_shifter.sv
src/weights_rotator.sv
src/stream_join.sv
src/axis_input_pipe.sv
dv/tb_clock.sv
dv/axis_input_pipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module axis_input_pipe_tb -Mdir obj_dir || exit 1
sim_out="$(./obj_dir/Vaxis_input_pipe_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: dv/axis_input_pipe_tb.sv
module axis_input_pipe_tb;
  import input_pipe_pkg::*;

  localparam int UNITS      = 2;
  localparam int IN_WORDS   = 4;
  localparam int W_WORDS    = 6;
  localparam int W_DEPTH    = 32;
  localparam int MAX_BEATS  = 8;
  localparam int WAIT_LIMIT = 200;
  localparam int N_ROWS     = 5;

  typedef struct packed {
    kh_t  kernel_h;
    logic is_max;
    logic is_lrelu;
    int   depth;
    int   beats;
    int   in_pct;
    int   out_pct;
  } stim_t;

  // kernel_h, is_max, is_lrelu, weights depth, pixel beats, valid %, ready %
  stim_t stim [N_ROWS] = '{
    '{2'd3, 1'b0, 1'b1, 4, 3, 100, 100},
    '{2'd1, 1'b1, 1'b0, 3, 5, 100, 100},
    '{2'd3, 1'b1, 1'b1, 5, 4, 60, 50},
    '{2'd1, 1'b0, 1'b0, 32, 6, 70, 40},
    '{2'd3, 1'b0, 1'b0, 1, 2, 50, 70}
  };

  logic                 aclk;
  logic                 rst_n;
  logic                 s_pixels_1_valid;
  logic                 s_pixels_1_ready;
  word_t [IN_WORDS-1:0] s_pixels_1_data;
  logic                 s_pixels_1_last;
  logic                 s_pixels_2_valid;
  logic                 s_pixels_2_ready;
  word_t [IN_WORDS-1:0] s_pixels_2_data;
  logic                 s_pixels_2_last;
  logic                 s_weights_valid;
  logic                 s_weights_ready;
  word_t [W_WORDS-1:0]  s_weights_data;
  logic                 s_weights_last;
  logic                 m_valid;
  logic                 m_ready;
  word_t [UNITS-1:0]    m_pixels_1_data;
  word_t [UNITS-1:0]    m_pixels_2_data;
  word_t [W_WORDS-1:0]  m_weights_data;
  tuser_t               m_user;
  logic                 m_last;

  // Beats of the current packet, pixel beats use the low IN_WORDS words
  word_t [W_WORDS-1:0] pix [2][MAX_BEATS];
  word_t [W_WORDS-1:0] wts [W_DEPTH];
  logic [31:0]         rng [4];
  int                  errors;
  int                  timeouts;

  tb_clock i_clock (.*);

  axis_input_pipe i_axis_input_pipe (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // One generator per stream keeps the sequence independent of process order
  function automatic logic [31:0] next_rand(input int s);
    rng[s] = xorshift(rng[s]);
    return rng[s];
  endfunction

  task automatic count_wait(inout int waited, input string what);
    waited++;
    if (waited > WAIT_LIMIT && timeouts == 0) begin
      timeouts++;
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    end
  endtask

  task automatic check_words(input string what, input word_t [W_WORDS-1:0] got,
                             input word_t [W_WORDS-1:0] exp, input int n);
    for (int i = 0; i < n; i++) begin
      if (got[i] !== exp[i]) begin
        errors++;
        $display("Fail %0t: %s word %0d is %h, expected %h", $time, what, i, got[i], exp[i]);
      end
    end
  endtask

  task automatic check_user(input tuser_t got, input tuser_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: m_user is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: m_last is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic drive_stream(input int s, input logic v, input word_t [W_WORDS-1:0] d,
                              input logic l);
    case (s)
      0: begin
        s_weights_valid <= v;
        s_weights_data  <= d;
        s_weights_last  <= l;
      end
      1: begin
        s_pixels_1_valid <= v;
        s_pixels_1_data  <= d[IN_WORDS-1:0];
        s_pixels_1_last  <= l;
      end
      default: begin
        s_pixels_2_valid <= v;
        s_pixels_2_data  <= d[IN_WORDS-1:0];
        s_pixels_2_last  <= l;
      end
    endcase
  endtask

  function automatic logic stream_ready(input int s);
    case (s)
      0: return s_weights_ready;
      1: return s_pixels_1_ready;
      default: return s_pixels_2_ready;
    endcase
  endfunction

  // Starts and ends on a rising edge, the beat transfers on the closing edge
  task automatic send_beat(input int s, input word_t [W_WORDS-1:0] d, input logic l,
                           input int pct);
    int waited;
    waited = 0;
    for (int g = 0; g < 4 && next_rand(s) % 100 >= pct; g++) begin
      drive_stream(s, 1'b0, d, l);
      @(posedge aclk);
    end
    drive_stream(s, 1'b1, d, l);
    @(negedge aclk);
    while (!stream_ready(s) && timeouts == 0) begin
      count_wait(waited, "input ready");
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  task automatic send_pixels(input int s, input stim_t st);
    word_t [W_WORDS-1:0] cfg;
    cfg    = '0;
    cfg[0] = word_t'(st.kernel_h);
    cfg[1] = word_t'({st.is_lrelu, st.is_max});
    if (s == 1) begin
      send_beat(1, cfg, 1'b0, st.in_pct);
    end
    for (int b = 0; b < st.beats && timeouts == 0; b++) begin
      send_beat(s, pix[s-1][b], b == st.beats - 1, st.in_pct);
    end
    drive_stream(s, 1'b0, '0, 1'b0);
  endtask

  task automatic collect_packet(input stim_t st);
    int                  n_out;
    int                  waited;
    int                  b;
    int                  r;
    word_t [W_WORDS-1:0] exp_p1;
    word_t [W_WORDS-1:0] exp_p2;
    word_t [W_WORDS-1:0] got_p1;
    word_t [W_WORDS-1:0] got_p2;
    n_out = st.beats * int'(st.kernel_h);
    for (int k = 0; k < n_out && timeouts == 0; k++) begin
      b      = k / int'(st.kernel_h);
      r      = k % int'(st.kernel_h);
      exp_p1 = '0;
      exp_p2 = '0;
      // Row r holds the words starting at word r
      for (int u = 0; u < UNITS; u++) begin
        exp_p1[u] = pix[0][b][r + u];
        exp_p2[u] = pix[1][b][r + u];
      end
      waited = 0;
      do begin
        @(posedge aclk);
        m_ready <= (next_rand(3) % 100 < st.out_pct);
        @(negedge aclk);
        count_wait(waited, "output beat");
      end while (!(m_valid && m_ready) && timeouts == 0);
      got_p1            = '0;
      got_p2            = '0;
      got_p1[UNITS-1:0] = m_pixels_1_data;
      got_p2[UNITS-1:0] = m_pixels_2_data;
      check_words("pixels 1", got_p1, exp_p1, UNITS);
      check_words("pixels 2", got_p2, exp_p2, UNITS);
      // Stored beats replay newest first and wrap
      check_words("weights", m_weights_data, wts[st.depth - 1 - k % st.depth], W_WORDS);
      check_user(m_user, {st.is_lrelu, st.is_max, kh_t'(r)});
      check_last(m_last, k == n_out - 1);
    end
    @(posedge aclk);
    m_ready <= 1'b0;
  endtask

  task automatic run_packet(input stim_t st);
    for (int b = 0; b < st.beats; b++) begin
      pix[0][b] = '0;
      pix[1][b] = '0;
      for (int w = 0; w < IN_WORDS; w++) begin
        pix[0][b][w] = word_t'(next_rand(3));
        pix[1][b][w] = word_t'(next_rand(3));
      end
    end
    for (int i = 0; i < st.depth; i++) begin
      for (int w = 0; w < W_WORDS; w++) begin
        wts[i][w] = word_t'(next_rand(3));
      end
    end
    for (int i = 0; i < st.depth && timeouts == 0; i++) begin
      send_beat(0, wts[i], i == st.depth - 1, st.in_pct);
    end
    drive_stream(0, 1'b0, '0, 1'b0);
    fork
      send_pixels(1, st);
      send_pixels(2, st);
      collect_packet(st);
    join
  endtask

  initial begin
    int waited;
    s_pixels_1_valid = 1'b0;
    s_pixels_1_data  = '0;
    s_pixels_1_last  = 1'b0;
    s_pixels_2_valid = 1'b0;
    s_pixels_2_data  = '0;
    s_pixels_2_last  = 1'b0;
    s_weights_valid  = 1'b0;
    s_weights_data   = '0;
    s_weights_last   = 1'b0;
    m_ready          = 1'b0;
    errors           = 0;
    timeouts         = 0;
    for (int i = 0; i < 4; i++) begin
      rng[i] = 32'd63 + i;
    end
    waited = 0;
    while (rst_n !== 1'b1 && timeouts == 0) begin
      @(posedge aclk);
      count_wait(waited, "reset release");
    end
    @(negedge aclk);
    if (m_valid !== 1'b0 || s_weights_ready !== 1'b1 || s_pixels_1_ready !== 1'b1 ||
        s_pixels_2_ready !== 1'b0) begin
      errors++;
      $display("Fail %0t: valid and ready levels are wrong after reset", $time);
    end
    @(posedge aclk);
    for (int i = 0; i < N_ROWS && timeouts == 0; i++) begin
      run_packet(stim[i]);
    end
    $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic aclk,
  output logic rst_n
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

  // Released on a rising edge like any other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    rst_n <= 1'b1;
  end

endmodule

// File: src/axis_input_pipe.sv
module axis_input_pipe #(
  parameter int  UNITS        = 2,
  parameter int  KERNEL_H_MAX = 3,
  parameter int  CORES        = 2,
  parameter int  KERNEL_W_MAX = 3,
  parameter int  W_DEPTH_MAX  = 32,
  localparam int IN_WORDS     = 2 ** $clog2(UNITS + KERNEL_H_MAX - 1)
) (
  input  logic                                           aclk,
  input  logic                                           rst_n,
  input  logic                                           s_pixels_1_valid,
  output logic                                           s_pixels_1_ready,
  input  input_pipe_pkg::word_t [IN_WORDS-1:0]           s_pixels_1_data,
  input  logic                                           s_pixels_1_last,
  input  logic                                           s_pixels_2_valid,
  output logic                                           s_pixels_2_ready,
  input  input_pipe_pkg::word_t [IN_WORDS-1:0]           s_pixels_2_data,
  input  logic                                           s_pixels_2_last,
  input  logic                                           s_weights_valid,
  output logic                                           s_weights_ready,
  input  input_pipe_pkg::word_t [CORES*KERNEL_W_MAX-1:0] s_weights_data,
  input  logic                                           s_weights_last,
  output logic                                           m_valid,
  input  logic                                           m_ready,
  output input_pipe_pkg::word_t [UNITS-1:0]              m_pixels_1_data,
  output input_pipe_pkg::word_t [UNITS-1:0]              m_pixels_2_data,
  output input_pipe_pkg::word_t [CORES*KERNEL_W_MAX-1:0] m_weights_data,
  output input_pipe_pkg::tuser_t                         m_user,
  output logic                                           m_last
);
  import input_pipe_pkg::*;

  logic p1_valid;
  logic p1_ready;
  kh_t  p1_row;
  logic p1_last;
  logic p2_valid;
  logic p2_ready;
  kh_t  p2_row;
  logic w_valid;
  logic w_ready;
  kh_t  cfg_kernel_h;
  logic cfg_is_max;
  logic cfg_is_lrelu;
  logic packet_done;

  // Stream 1 carries the config beat
  im_shifter #(
    .UNITS        (UNITS),
    .KERNEL_H_MAX (KERNEL_H_MAX),
    .IN_WORDS     (IN_WORDS),
    .HAS_CONFIG   (1'b1)
  ) i_shifter_1 (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .s_valid      (s_pixels_1_valid),
    .s_ready      (s_pixels_1_ready),
    .s_data       (s_pixels_1_data),
    .s_last       (s_pixels_1_last),
    .kernel_h_in  (2'd0),
    .m_valid      (p1_valid),
    .m_ready      (p1_ready),
    .m_data       (m_pixels_1_data),
    .m_row        (p1_row),
    .m_last       (p1_last),
    .cfg_kernel_h (cfg_kernel_h),
    .cfg_is_max   (cfg_is_max),
    .cfg_is_lrelu (cfg_is_lrelu)
  );

  im_shifter #(
    .UNITS        (UNITS),
    .KERNEL_H_MAX (KERNEL_H_MAX),
    .IN_WORDS     (IN_WORDS),
    .HAS_CONFIG   (1'b0)
  ) i_shifter_2 (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .s_valid      (s_pixels_2_valid),
    .s_ready      (s_pixels_2_ready),
    .s_data       (s_pixels_2_data),
    .s_last       (s_pixels_2_last),
    .kernel_h_in  (cfg_kernel_h),
    .m_valid      (p2_valid),
    .m_ready      (p2_ready),
    .m_data       (m_pixels_2_data),
    .m_row        (p2_row),
    .m_last       (),
    .cfg_kernel_h (),
    .cfg_is_max   (),
    .cfg_is_lrelu ()
  );

  weights_rotator #(
    .CORES        (CORES),
    .KERNEL_W_MAX (KERNEL_W_MAX),
    .W_DEPTH_MAX  (W_DEPTH_MAX)
  ) i_weights_rotator (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .s_valid      (s_weights_valid),
    .s_ready      (s_weights_ready),
    .s_data       (s_weights_data),
    .s_last       (s_weights_last),
    .m_valid      (w_valid),
    .m_ready      (w_ready),
    .m_data       (m_weights_data),
    .packet_done  (packet_done)
  );

  stream_join i_join (
    .pixels_1_valid (p1_valid),
    .pixels_1_ready (p1_ready),
    .pixels_2_valid (p2_valid),
    .pixels_2_ready (p2_ready),
    .weights_valid  (w_valid),
    .weights_ready  (w_ready),
    .pixels_1_row   (p1_row),
    .pixels_2_row   (p2_row),
    .pixels_1_last  (p1_last),
    .is_max         (cfg_is_max),
    .is_lrelu       (cfg_is_lrelu),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .m_user         (m_user),
    .m_last         (m_last),
    .packet_done    (packet_done)
  );

endmodule

// File: src/stream_join.sv
module stream_join (
  input  logic                   pixels_1_valid,
  output logic                   pixels_1_ready,
  input  logic                   pixels_2_valid,
  output logic                   pixels_2_ready,
  input  logic                   weights_valid,
  output logic                   weights_ready,
  input  input_pipe_pkg::kh_t    pixels_1_row,
  input  input_pipe_pkg::kh_t    pixels_2_row,
  input  logic                   pixels_1_last,
  input  logic                   is_max,
  input  logic                   is_lrelu,
  output logic                   m_valid,
  input  logic                   m_ready,
  output input_pipe_pkg::tuser_t m_user,
  output logic                   m_last,
  output logic                   packet_done
);
  import input_pipe_pkg::*;

  assign m_valid = pixels_1_valid && pixels_2_valid && weights_valid;

  // Each side sees ready only when the other two are there
  assign pixels_1_ready = m_ready && pixels_2_valid && weights_valid;
  assign pixels_2_ready = m_ready && pixels_1_valid && weights_valid;
  assign weights_ready  = m_ready && pixels_1_valid && pixels_2_valid;

  always_comb begin
    m_user                    = '0;
    m_user[$bits(kh_t)-1:0]   = pixels_1_row;
    m_user[I_USER_IS_MAX]     = is_max;
    m_user[I_USER_IS_LRELU]   = is_lrelu;
  end

  assign m_last      = pixels_1_last;
  assign packet_done = m_valid && m_ready && pixels_1_last;

  // Both shifters must step their rows in lock
  always_comb begin
    a_row_align: assert final (!m_valid || pixels_1_row == pixels_2_row);
  end

endmodule

// File: src/weights_rotator.sv
module weights_rotator #(
  parameter int CORES        = 2,
  parameter int KERNEL_W_MAX = 3,
  parameter int W_DEPTH_MAX  = 32
) (
  input  logic                                             aclk,
  input  logic                                             rst_n,
  input  logic                                             s_valid,
  output logic                                             s_ready,
  input  input_pipe_pkg::word_t [CORES*KERNEL_W_MAX-1:0]   s_data,
  input  logic                                             s_last,
  output logic                                             m_valid,
  input  logic                                             m_ready,
  output input_pipe_pkg::word_t [CORES*KERNEL_W_MAX-1:0]   m_data,
  input  logic                                             packet_done
);
  import input_pipe_pkg::*;

  localparam int W_WORDS    = CORES * KERNEL_W_MAX;
  localparam int ADDR_BITS  = $clog2(W_DEPTH_MAX);
  localparam int DEPTH_BITS = $clog2(W_DEPTH_MAX + 1);

  rot_state_t            state;
  word_t [W_WORDS-1:0]   mem [W_DEPTH_MAX];
  logic [DEPTH_BITS-1:0] depth;
  logic [DEPTH_BITS-1:0] depth_m1;
  logic [ADDR_BITS-1:0]  rd_ptr;
  logic                  s_fire;
  logic                  m_fire;

  assign s_ready  = (state == RT_LOAD);
  assign m_valid  = (state == RT_PLAY);
  assign s_fire   = s_valid && s_ready;
  assign m_fire   = m_valid && m_ready;
  assign depth_m1 = depth - 1'b1;
  assign m_data   = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state  <= RT_LOAD;
      depth  <= '0;
      rd_ptr <= '0;
    end else if (packet_done) begin
      state <= RT_LOAD;
      depth <= '0;
    end else if (s_fire) begin
      depth <= depth + 1'b1;
      if (s_last) begin
        // Playback starts from the newest beat
        rd_ptr <= depth[ADDR_BITS-1:0];
        state  <= RT_PLAY;
      end
    end else if (m_fire) begin
      // Wrap back to the top after index 0
      if (rd_ptr == '0) begin
        rd_ptr <= depth_m1[ADDR_BITS-1:0];
      end else begin
        rd_ptr <= rd_ptr - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      mem[depth[ADDR_BITS-1:0]] <= s_data;
    end
  end

  a_depth_max: assert property (@(posedge aclk) disable iff (!rst_n)
    s_fire |=> depth <= W_DEPTH_MAX);

endmodule

// File: src/im_shifter.sv
module im_shifter #(
  parameter int UNITS        = 2,
  parameter int KERNEL_H_MAX = 3,
  parameter int IN_WORDS     = 4,
  parameter bit HAS_CONFIG   = 1'b1
) (
  input  logic                                 aclk,
  input  logic                                 rst_n,
  input  logic                                 s_valid,
  output logic                                 s_ready,
  input  input_pipe_pkg::word_t [IN_WORDS-1:0] s_data,
  input  logic                                 s_last,
  input  input_pipe_pkg::kh_t                  kernel_h_in,
  output logic                                 m_valid,
  input  logic                                 m_ready,
  output input_pipe_pkg::word_t [UNITS-1:0]    m_data,
  output input_pipe_pkg::kh_t                  m_row,
  output logic                                 m_last,
  output input_pipe_pkg::kh_t                  cfg_kernel_h,
  output logic                                 cfg_is_max,
  output logic                                 cfg_is_lrelu
);
  import input_pipe_pkg::*;

  // Words past this count are padding
  localparam int EDGE_WORDS = UNITS + KERNEL_H_MAX - 1;
  localparam shift_state_t START_STATE = HAS_CONFIG ? SH_CONFIG : SH_IDLE;

  shift_state_t         state;
  word_t [IN_WORDS-1:0] beat_q;
  logic                 last_q;
  kh_t                  kh_q;
  kh_t                  row;
  kh_t                  kernel_h_eff;
  logic                 s_fire;
  logic                 m_fire;
  logic                 final_row;

  assign kernel_h_eff = HAS_CONFIG ? cfg_kernel_h : kernel_h_in;

  // A zero height means no config has arrived yet
  assign s_ready = (state == SH_CONFIG) || (state == SH_IDLE && kernel_h_eff != '0);
  assign s_fire  = s_valid && s_ready;

  assign m_valid   = (state == SH_EMIT);
  assign m_fire    = m_valid && m_ready;
  assign final_row = (row == kh_q - 2'd1);
  assign m_row     = row;
  assign m_last    = last_q && final_row;

  // Row r takes the UNITS words starting at word r
  always_comb begin
    int idx;
    for (int u = 0; u < UNITS; u++) begin
      idx       = int'(row) + u;
      m_data[u] = (idx < EDGE_WORDS) ? beat_q[idx] : '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state        <= START_STATE;
      row          <= '0;
      kh_q         <= '0;
      last_q       <= 1'b0;
      cfg_kernel_h <= '0;
      cfg_is_max   <= 1'b0;
      cfg_is_lrelu <= 1'b0;
    end else begin
      case (state)
        SH_CONFIG: begin
          if (s_fire) begin
            cfg_kernel_h <= s_data[0][1:0];
            cfg_is_max   <= s_data[1][0];
            cfg_is_lrelu <= s_data[1][1];
            state        <= SH_IDLE;
          end
        end
        SH_IDLE: begin
          if (s_fire) begin
            kh_q   <= kernel_h_eff;
            last_q <= s_last;
            state  <= SH_EMIT;
          end
        end
        SH_EMIT: begin
          if (m_fire) begin
            if (final_row) begin
              row <= '0;
              if (HAS_CONFIG && last_q) begin
                // Holds the other stream off until the next config
                cfg_kernel_h <= '0;
                state        <= SH_CONFIG;
              end else begin
                state <= SH_IDLE;
              end
            end else begin
              row <= row + 2'd1;
            end
          end
        end
        default: state <= START_STATE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire && state == SH_IDLE) begin
      beat_q <= s_data;
    end
  end

  // Stream 2 takes its height from stream 1
  a_kernel_h: assert property (@(posedge aclk) disable iff (!rst_n)
    s_fire && state == SH_IDLE |-> kernel_h_eff == 2'd1 || kernel_h_eff == 2'd3);

  a_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_row));

endmodule

// File: src/input_pipe_pkg.sv
package input_pipe_pkg;

  localparam int WORD_WIDTH  = 8;
  localparam int TUSER_WIDTH = 4;

  // One pixel or weight word
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Kernel height, or a row index inside the kernel
  typedef logic [1:0] kh_t;

  typedef logic [TUSER_WIDTH-1:0] tuser_t;

  // Flag positions in tuser, the row index sits in the low bits
  localparam int I_USER_IS_MAX   = 2;
  localparam int I_USER_IS_LRELU = 3;

  typedef enum logic [1:0] {
    SH_CONFIG,
    SH_IDLE,
    SH_EMIT
  } shift_state_t;

  typedef enum logic {
    RT_LOAD,
    RT_PLAY
  } rot_state_t;

endpackage
